// ==== spi_bus_pkg.sv ====
package spi_bus_pkg;

    // ----------------------------------------
    // Wire format
    // ----------------------------------------

    // One byte as it travels on MOSI or MISO
    typedef logic [7:0] spi_byte_t;

    // Card reader register address
    typedef logic [6:0] reg_addr_t;

    // Read/write flag position in the address byte
    // Flag set to 1 means a register read
    localparam int RW_BIT = 7;

    // Bits per byte on the wire, MSB first
    localparam int FRAME_BITS = 8;

    // ----------------------------------------
    // Serial clock
    // ----------------------------------------

    // clk cycles per SCK half period
    // One SCK bit takes twice this many clk cycles
    localparam int SCK_HALF_CYCLES = 4;

endpackage

// ==== spi_ctrl_pkg.sv ====
package spi_ctrl_pkg;

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------

    // Transaction states in the order they are walked
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CS_SETUP,
        ST_ADDR_PHASE,
        ST_WRITE_PHASE,
        ST_READ_PHASE,
        ST_CS_HOLD
    } seq_state_t;

    // Chip select setup and hold gap in clk cycles
    localparam int GUARD_CYCLES = 2;

    // Bit index inside one byte
    typedef logic [2:0] bit_count_t;

endpackage

// ==== spi_clock_gen.sv ====
`timescale 1ns/1ps

module spi_clock_gen (
    input  logic clk,
    input  logic rst,
    input  logic sck_run,
    output logic sck,
    output logic sck_rise,
    output logic sck_fall
);

    // Counter over one SCK half period
    typedef logic [$clog2(spi_bus_pkg::SCK_HALF_CYCLES)-1:0] div_cnt_t;

    div_cnt_t div_cnt;
    logic     half_done;

    // Last clk cycle of the running half period
    assign half_done = (div_cnt == div_cnt_t'(spi_bus_pkg::SCK_HALF_CYCLES - 1));

    // ----------------------------------------
    // Divider and edge strobes
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt  <= '0;
            sck      <= 1'b0;
            sck_rise <= 1'b0;
            sck_fall <= 1'b0;
        end else begin
            // Strobes live for one cycle only
            sck_rise <= 1'b0;
            sck_fall <= 1'b0;
            if (!sck_run) begin
                // Stopped, SCK parks at its mode 0 idle level
                div_cnt <= '0;
                sck     <= 1'b0;
            end else if (half_done) begin
                div_cnt  <= '0;
                sck      <= ~sck;
                // Strobe marks the new level of SCK
                sck_rise <= ~sck;
                sck_fall <= sck;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Sequencer only stops SCK in a low half period, so SCK is idle while stopped
    assert property (@(posedge clk) disable iff (rst) !sck_run |-> !sck)
        else $error("sck high while sck_run is low");

endmodule

// ==== spi_tx_shifter.sv ====
`timescale 1ns/1ps

module spi_tx_shifter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_addr,
    input  logic                   load_data,
    input  logic                   rw,
    input  spi_bus_pkg::reg_addr_t addr,
    input  spi_bus_pkg::spi_byte_t data_in,
    input  logic                   sck_fall,
    output logic                   mosi
);

    spi_bus_pkg::spi_byte_t addr_byte;
    spi_bus_pkg::spi_byte_t data_hold;
    spi_bus_pkg::spi_byte_t shift_reg;

    // Address byte with the direction flag on top
    always_comb begin
        addr_byte = spi_bus_pkg::spi_byte_t'(addr);
        addr_byte[spi_bus_pkg::RW_BIT] = rw;
    end

    // ----------------------------------------
    // Data byte holding register
    // ----------------------------------------

    // Request inputs are only valid with the start strobe
    // Byte waits here until the address has gone out
    always_ff @(posedge clk) begin
        if (load_addr) begin
            // Read sends all zeros in its second byte
            data_hold <= rw ? '0 : data_in;
        end
    end

    // ----------------------------------------
    // Shift register
    // ----------------------------------------

    // Loads win over a shift in the same cycle
    // load_data lands on the eighth falling edge
    always_ff @(posedge clk) begin
        if (rst) begin
            shift_reg <= '0;
        end else if (load_addr) begin
            shift_reg <= addr_byte;
        end else if (load_data) begin
            shift_reg <= data_hold;
        end else if (sck_fall) begin
            // Next bit up, zero fill keeps MOSI low afterwards
            shift_reg <= {shift_reg[6:0], 1'b0};
        end
    end

    // MSB first on the wire
    assign mosi = shift_reg[7];

endmodule

// ==== spi_rx_shifter.sv ====
`timescale 1ns/1ps

module spi_rx_shifter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   capture,
    input  logic                   sck_rise,
    input  logic                   miso,
    output spi_bus_pkg::spi_byte_t data_out
);

    spi_bus_pkg::spi_byte_t   shift_reg;
    spi_ctrl_pkg::bit_count_t bit_cnt;
    logic                     byte_full;
    logic                     last_bit;

    // Sample that completes the byte
    assign last_bit = (bit_cnt == spi_ctrl_pkg::bit_count_t'(spi_bus_pkg::FRAME_BITS - 1));

    // Sample path, MSB arrives first
    always_ff @(posedge clk) begin
        if (capture && sck_rise) begin
            shift_reg <= {shift_reg[6:0], miso};
        end
    end

    // Own bit count, cleared whenever capture is off
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt   <= '0;
            byte_full <= 1'b0;
            data_out  <= '0;
        end else if (!capture) begin
            bit_cnt   <= '0;
            byte_full <= 1'b0;
        end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit) begin
                // Result held until the next read completes
                data_out  <= {shift_reg[6:0], miso};
                byte_full <= 1'b1;
            end
        end
    end

    // Read phase ends before a ninth sample edge comes along
    assert property (@(posedge clk) disable iff (rst) !(capture && sck_rise && byte_full))
        else $error("sck_rise with a full receive byte");

endmodule

// ==== spi_sequencer.sv ====
`timescale 1ns/1ps

module spi_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic rw,
    input  logic sck_rise,
    input  logic sck_fall,
    output logic cs_n,
    output logic busy,
    output logic done,
    output logic sck_run,
    output logic load_addr,
    output logic load_data,
    output logic capture
);

    // Counter over one chip select gap
    typedef logic [$clog2(spi_ctrl_pkg::GUARD_CYCLES)-1:0] guard_cnt_t;

    spi_ctrl_pkg::seq_state_t state;
    spi_ctrl_pkg::bit_count_t bit_cnt;
    guard_cnt_t               guard_cnt;
    logic                     rw_q;
    logic                     guard_end;
    logic                     byte_end;

    // Last cycle of a setup or hold gap
    assign guard_end = (guard_cnt == guard_cnt_t'(spi_ctrl_pkg::GUARD_CYCLES - 1));

    // Eighth falling edge of the running byte
    assign byte_end = sck_fall &&
        (bit_cnt == spi_ctrl_pkg::bit_count_t'(spi_bus_pkg::FRAME_BITS - 1));

    // ----------------------------------------
    // Datapath controls
    // ----------------------------------------

    // Accepted request, shifter samples rw, addr and data_in now
    assign load_addr = (state == spi_ctrl_pkg::ST_IDLE) && en;
    // Second byte replaces the shift on the eighth falling edge
    assign load_data = (state == spi_ctrl_pkg::ST_ADDR_PHASE) && byte_end;
    assign capture   = (state == spi_ctrl_pkg::ST_READ_PHASE);
    // SCK runs straight through both bytes
    assign sck_run   = (state == spi_ctrl_pkg::ST_ADDR_PHASE) ||
                       (state == spi_ctrl_pkg::ST_WRITE_PHASE) ||
                       (state == spi_ctrl_pkg::ST_READ_PHASE);

    // ----------------------------------------
    // State machine
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= spi_ctrl_pkg::ST_IDLE;
            bit_cnt   <= '0;
            guard_cnt <= '0;
            rw_q      <= 1'b0;
            cs_n      <= 1'b1;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                spi_ctrl_pkg::ST_IDLE: begin
                    // en while busy never reaches here
                    if (en) begin
                        state     <= spi_ctrl_pkg::ST_CS_SETUP;
                        rw_q      <= rw;
                        bit_cnt   <= '0;
                        guard_cnt <= '0;
                        cs_n      <= 1'b0;
                        busy      <= 1'b1;
                    end
                end
                spi_ctrl_pkg::ST_CS_SETUP: begin
                    if (guard_end) begin
                        state     <= spi_ctrl_pkg::ST_ADDR_PHASE;
                        guard_cnt <= '0;
                    end else begin
                        guard_cnt <= guard_cnt + 1'b1;
                    end
                end
                spi_ctrl_pkg::ST_ADDR_PHASE: begin
                    // Count wraps to zero for the second byte
                    if (sck_fall) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    if (byte_end) begin
                        state <= rw_q ? spi_ctrl_pkg::ST_READ_PHASE
                                      : spi_ctrl_pkg::ST_WRITE_PHASE;
                    end
                end
                spi_ctrl_pkg::ST_WRITE_PHASE,
                spi_ctrl_pkg::ST_READ_PHASE: begin
                    if (sck_fall) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    if (byte_end) begin
                        state <= spi_ctrl_pkg::ST_CS_HOLD;
                    end
                end
                spi_ctrl_pkg::ST_CS_HOLD: begin
                    // cs_n, busy and done all switch on one edge
                    if (guard_end) begin
                        state     <= spi_ctrl_pkg::ST_IDLE;
                        guard_cnt <= '0;
                        cs_n      <= 1'b1;
                        busy      <= 1'b0;
                        done      <= 1'b1;
                    end else begin
                        guard_cnt <= guard_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= spi_ctrl_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Completion pulse only after the bus is released
    assert property (@(posedge clk) disable iff (rst) done |-> (!busy && cs_n))
        else $error("done while transaction still active");

    // Clock activity only inside the chip select window
    assert property (@(posedge clk) disable iff (rst) (sck_run || sck_rise || sck_fall) |-> !cs_n)
        else $error("sck activity with cs_n high");

endmodule

// ==== spi_master_top.sv ====
`timescale 1ns/1ps

module spi_master_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    input  logic                   rw,
    input  spi_bus_pkg::reg_addr_t addr,
    input  spi_bus_pkg::spi_byte_t data_in,
    input  logic                   miso,
    output logic                   cs_n,
    output logic                   sck,
    output logic                   mosi,
    output spi_bus_pkg::spi_byte_t data_out,
    output logic                   busy,
    output logic                   done
);

    // Sequencer to clock generator
    logic sck_run;
    // Edge strobes back from the clock generator
    logic sck_rise;
    logic sck_fall;
    // Shifter controls
    logic load_addr;
    logic load_data;
    logic capture;

    // ----------------------------------------
    // Control
    // ----------------------------------------

    spi_sequencer i_sequencer (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .rw        (rw),
        .sck_rise  (sck_rise),
        .sck_fall  (sck_fall),
        .cs_n      (cs_n),
        .busy      (busy),
        .done      (done),
        .sck_run   (sck_run),
        .load_addr (load_addr),
        .load_data (load_data),
        .capture   (capture)
    );

    spi_clock_gen i_clock_gen (
        .clk      (clk),
        .rst      (rst),
        .sck_run  (sck_run),
        .sck      (sck),
        .sck_rise (sck_rise),
        .sck_fall (sck_fall)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    spi_tx_shifter i_tx_shifter (
        .clk       (clk),
        .rst       (rst),
        .load_addr (load_addr),
        .load_data (load_data),
        .rw        (rw),
        .addr      (addr),
        .data_in   (data_in),
        .sck_fall  (sck_fall),
        .mosi      (mosi)
    );

    spi_rx_shifter i_rx_shifter (
        .clk      (clk),
        .rst      (rst),
        .capture  (capture),
        .sck_rise (sck_rise),
        .miso     (miso),
        .data_out (data_out)
    );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held over three rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== tb_spi_master.sv ====
`timescale 1ns/1ps

module tb_spi_master;

    localparam int NUM_TESTS  = 14;
    localparam int NUM_FIXED  = 6;
    localparam int FRAME_RISE = 2 * spi_bus_pkg::FRAME_BITS;
    // Two bytes of SCK, each bit two half periods
    localparam int FRAME_CYCLES = FRAME_RISE * 2 * spi_bus_pkg::SCK_HALF_CYCLES;
    // Frame plus guard gaps, ignored request and slack
    localparam int TEST_CYCLES = FRAME_CYCLES + 72;

    logic                   clk;
    logic                   rst;
    logic                   en;
    logic                   rw;
    spi_bus_pkg::reg_addr_t addr;
    spi_bus_pkg::spi_byte_t data_in;
    logic                   miso;
    logic                   cs_n;
    logic                   sck;
    logic                   mosi;
    spi_bus_pkg::spi_byte_t data_out;
    logic                   busy;
    logic                   done;

    // Stimulus columns, then expected frame and data_out per row
    logic                   tbl_rw    [NUM_TESTS];
    spi_bus_pkg::reg_addr_t tbl_addr  [NUM_TESTS];
    spi_bus_pkg::spi_byte_t tbl_wdata [NUM_TESTS];
    spi_bus_pkg::spi_byte_t tbl_reply [NUM_TESTS];
    logic [15:0]            tbl_frame [NUM_TESTS];
    spi_bus_pkg::spi_byte_t tbl_dout  [NUM_TESTS];

    // Slave model state
    spi_bus_pkg::spi_byte_t cur_reply;
    logic [15:0]            mosi_bits;
    logic [15:0]            last_frame;
    int                     rise_cnt;
    int                     fall_cnt;
    int                     last_rises;
    int                     frame_count;
    int                     error_count;
    logic                   prev_cs_n;
    logic                   prev_sck;

    tb_clock i_clock (
        .clk (clk),
        .rst (rst)
    );

    spi_master_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .rw       (rw),
        .addr     (addr),
        .data_in  (data_in),
        .miso     (miso),
        .cs_n     (cs_n),
        .sck      (sck),
        .mosi     (mosi),
        .data_out (data_out),
        .busy     (busy),
        .done     (done)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic set_row(input int i, input logic r, input spi_bus_pkg::reg_addr_t a,
                           input spi_bus_pkg::spi_byte_t d, input spi_bus_pkg::spi_byte_t rep);
        tbl_rw[i]    = r;
        tbl_addr[i]  = a;
        tbl_wdata[i] = d;
        tbl_reply[i] = rep;
    endtask

    task automatic build_table();
        logic [31:0]            rng;
        spi_bus_pkg::spi_byte_t dout;
        // Corners, first row a write so data_out must still be zero
        set_row(0, 1'b0, 7'h00, 8'h00, 8'h5a);
        set_row(1, 1'b0, 7'h7f, 8'hff, 8'h00);
        set_row(2, 1'b1, 7'h00, 8'h3c, 8'ha5);
        set_row(3, 1'b0, 7'h2a, 8'ha5, 8'hc3);
        set_row(4, 1'b1, 7'h7f, 8'h00, 8'hff);
        set_row(5, 1'b1, 7'h55, 8'hff, 8'h00);
        rng = 32'h97e00c59;
        for (int i = NUM_FIXED; i < NUM_TESTS; i++) begin
            rng = xorshift32(rng);
            set_row(i, rng[0], rng[14:8], rng[23:16], rng[31:24]);
        end
        // Flag, address, then data byte or zeros on a read
        dout = '0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            tbl_frame[i] = {tbl_rw[i], tbl_addr[i], tbl_rw[i] ? 8'h00 : tbl_wdata[i]};
            if (tbl_rw[i]) begin
                dout = tbl_reply[i];
            end
            tbl_dout[i] = dout;
        end
    endtask

    task automatic run_row(input int i);
        string name;
        name = $sformatf("row %0d", i);
        @(negedge clk);
        rw        = tbl_rw[i];
        addr      = tbl_addr[i];
        data_in   = tbl_wdata[i];
        cur_reply = tbl_reply[i];
        en        = 1'b1;
        @(negedge clk);
        en = 1'b0;
        // Scrambled request, must not leak into the frame
        rw      = ~rw;
        addr    = ~addr;
        data_in = ~data_in;
        repeat (20) @(negedge clk);
        check_value({name, " busy"}, 1, busy);
        // Second request in mid frame, to be dropped
        en = 1'b1;
        @(negedge clk);
        en = 1'b0;
        while (!done) begin
            @(negedge clk);
        end
        check_value({name, " cs_n idle"}, 1, cs_n);
        check_value({name, " sck idle"}, 0, sck);
        check_value({name, " busy idle"}, 0, busy);
        check_value({name, " data_out"}, tbl_dout[i], data_out);
        @(negedge clk);
        check_value({name, " done width"}, 0, done);
        check_value({name, " sck rises"}, FRAME_RISE, last_rises);
        check_value({name, " mosi frame"}, tbl_frame[i], last_frame);
    endtask

    // ----------------------------------------
    // Slave model, sampled on falling clk
    // ----------------------------------------

    always @(negedge clk) begin
        if (!rst) begin
            if (cs_n !== prev_cs_n) begin
                check_value("sck at cs_n edge", 0, sck);
                if (!cs_n) begin
                    frame_count++;
                    rise_cnt  = 0;
                    fall_cnt  = 0;
                    mosi_bits = '0;
                    // Garbage during the address byte is the inverted reply
                    miso = ~cur_reply[7];
                end else begin
                    last_rises = rise_cnt;
                    last_frame = mosi_bits;
                end
            end
            if (!cs_n && sck && !prev_sck) begin
                rise_cnt++;
                mosi_bits = {mosi_bits[14:0], mosi};
            end
            if (!cs_n && !sck && prev_sck) begin
                fall_cnt++;
                if (fall_cnt < spi_bus_pkg::FRAME_BITS) begin
                    miso = ~cur_reply[7 - fall_cnt];
                end else if (fall_cnt < FRAME_RISE) begin
                    miso = cur_reply[FRAME_RISE - 1 - fall_cnt];
                end
            end
        end
        prev_cs_n = cs_n;
        prev_sck  = sck;
    end

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------

    initial begin
        en          = 1'b0;
        rw          = 1'b0;
        addr        = '0;
        data_in     = '0;
        miso        = 1'b0;
        cur_reply   = '0;
        mosi_bits   = '0;
        last_frame  = '0;
        rise_cnt    = 0;
        fall_cnt    = 0;
        last_rises  = 0;
        frame_count = 0;
        error_count = 0;
        prev_cs_n   = 1'b1;
        prev_sck    = 1'b0;
        build_table();
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        @(negedge clk);
        check_value("reset cs_n", 1, cs_n);
        check_value("reset sck", 0, sck);
        check_value("reset mosi", 0, mosi);
        check_value("reset busy", 0, busy);
        check_value("reset done", 0, done);
        check_value("reset data_out", 0, data_out);
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_row(i);
        end
        check_value("frame count", NUM_TESTS, frame_count);
        $display("Errors: %0d, frames seen: %0d of %0d", error_count, frame_count, NUM_TESTS);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * TEST_CYCLES + 100) @(posedge clk);
        $display("Timeout: transactions did not finish in time, %0d errors so far",
                 error_count);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== sources.f ====
spi_bus_pkg.sv
spi_ctrl_pkg.sv
spi_clock_gen.sv
spi_tx_shifter.sv
spi_rx_shifter.sv
spi_sequencer.sv
spi_master_top.sv
tb_clock.sv
tb_spi_master.sv
